/* logic/sensor_i2c_settings.svh */
/*
  sensor i2c sequencer settings
  page geometry, bus pacing and control word bit positions
*/
`ifndef SENSOR_I2C_SETTINGS_SVH
`define SENSOR_I2C_SETTINGS_SVH

`define SENSI2C_PAGES        16 // frame pages, one per frame mod 16
`define SENSI2C_PAGE_DEPTH   64 // command words per page
`define SENSI2C_QUARTER_DLY  4  // mclk cycles per quarter scl period

`define SENSI2C_CTRL_RESET   14 // reset all pages, stops the sequencer
`define SENSI2C_CTRL_RUN_SET 13 // apply run_val to run state
`define SENSI2C_CTRL_RUN_VAL 12 // 1 run, 0 stop

`endif

/* logic/i2c_seq_pkg.sv */
/*
  sequencer types
  frame pages, word pointers, command words and host write kinds
*/
package i2c_seq_pkg;

    typedef logic [3:0]  page_t;     // frame / page number
    typedef logic [5:0]  ptr_t;      // word index inside a page
    typedef logic [31:0] cmd_word_t; // one i2c write, msb byte first

    // what a host write means
    typedef enum logic [1:0] {
        kind_abs  = 2'd0, // page = frame number mod 16
        kind_rel  = 2'd1, // page = current frame + offset
        kind_ctrl = 2'd2  // control word
    } wr_kind_t;

endpackage

/* logic/i2c_bus_pkg.sv */
/*
  bus side types
  bus byte and transaction phase encoding
*/
package i2c_bus_pkg;

    typedef logic [7:0] byte_t; // one byte on sda

    typedef enum logic [2:0] {
        st_idle,  // bus free, both lines high
        st_start, // sda falls with scl high
        st_bits,  // eight data bits
        st_ack,   // sda released for the slave
        st_stop   // sda rises with scl high
    } byte_state_t;

endpackage

/* logic/cmd_port.sv */
/*
  host command port
  four-phase req/ack handshake, turns each accepted request into a
  single-cycle word write or control strobe
*/
`timescale 1ns/1ns
`include "sensor_i2c_settings.svh"

module cmd_port (
    input  logic                  mclk,
    input  logic                  reset_cmd,
    input  logic                  wr_req,
    input  i2c_seq_pkg::wr_kind_t wr_kind,
    input  i2c_seq_pkg::page_t    wr_page,
    input  i2c_seq_pkg::cmd_word_t wr_data,
    input  logic                  clearing,   // page reset in progress
    output logic                  wr_ack,
    output logic                  word_we,
    output logic                  word_rel,
    output i2c_seq_pkg::page_t    word_page,
    output logic                  page_reset,
    output logic                  run_set,
    output logic                  run_val
);

    logic accept; // new request taken this cycle

    assign accept = wr_req && !wr_ack && !clearing; // back-pressure while clearing

    always_ff @(posedge mclk) begin
        if (reset_cmd) begin
            wr_ack     <= 1'b0;
            word_we    <= 1'b0;
            page_reset <= 1'b0;
            run_set    <= 1'b0;
        end else begin
            word_we    <= accept && (wr_kind != i2c_seq_pkg::kind_ctrl); // store with ack
            page_reset <= accept && (wr_kind == i2c_seq_pkg::kind_ctrl)
                          && wr_data[`SENSI2C_CTRL_RESET];
            run_set    <= accept && (wr_kind == i2c_seq_pkg::kind_ctrl)
                          && wr_data[`SENSI2C_CTRL_RUN_SET];
            if (accept) begin
                wr_ack <= 1'b1; // phase 2
            end else if (wr_ack && !wr_req) begin
                wr_ack <= 1'b0; // phase 4
            end
        end
    end

    // strobe payload, valid with the strobes
    always_ff @(posedge mclk) begin
        if (accept) begin
            word_rel  <= (wr_kind == i2c_seq_pkg::kind_rel);
            word_page <= wr_page; // page or offset
            run_val   <= wr_data[`SENSI2C_CTRL_RUN_VAL];
        end
    end

endmodule

/* logic/page_pointers.sv */
/*
  page pointers
  frame counter, per-page write pointers, page clearing on frame sync
  and reset, read page/pointer tracking and sequencer run state
*/
`timescale 1ns/1ns
`include "sensor_i2c_settings.svh"

module page_pointers (
    input  logic                mclk,
    input  logic                reset_cmd,
    input  logic                frame_sync,
    input  logic                word_we,
    input  logic                word_rel,
    input  i2c_seq_pkg::page_t  word_page,
    input  logic                page_reset,
    input  logic                run_set,
    input  logic                run_val,
    input  logic                xfer_start,
    input  logic                xfer_done,
    output logic [9:0]          wr_addr,    // {page, pointer} of the word being stored
    output i2c_seq_pkg::page_t  rd_page,
    output i2c_seq_pkg::ptr_t   rd_ptr,
    output logic                word_ready,
    output logic                running,
    output logic                clearing,
    output logic                busy
);

    i2c_seq_pkg::page_t frame_cnt;   // current frame mod 16
    i2c_seq_pkg::page_t prev_page;   // page just left, next to clear
    i2c_seq_pkg::page_t wpage;       // target page of this write
    i2c_seq_pkg::ptr_t  wptr [`SENSI2C_PAGES]; // words written per page
    i2c_seq_pkg::ptr_t  rd_cnt;      // words in the read page
    logic               req_clr;     // frame sync waiting to advance
    logic               clear_en;    // clear prev_page and advance frame
    logic               has_words;   // unsent words left in read page
    logic               xfer_active; // transaction on the current word
    logic               page_inc;    // reader moves to next page

    // absolute writes to the page just left land in the current frame
    assign wpage = word_rel ? i2c_seq_pkg::page_t'(frame_cnt + word_page) :
                   (word_page == prev_page) ? frame_cnt : word_page;
    assign wr_addr = {wpage, wptr[wpage]};

    assign clear_en  = clearing || (req_clr && !word_we); // pending write goes first
    assign rd_cnt    = wptr[rd_page];
    assign has_words = (rd_ptr < rd_cnt);
    assign word_ready = running && has_words && !clearing;
    assign page_inc  = !xfer_active && !has_words && !clearing && (rd_page != frame_cnt);

    // pointer memory, one clear or one bump per cycle
    always_ff @(posedge mclk) begin
        if (clear_en) begin
            wptr[prev_page] <= '0;
        end else if (word_we) begin
            wptr[wpage] <= wptr[wpage] + 6'd1;
        end
    end

    always_ff @(posedge mclk) begin
        if (reset_cmd || page_reset) begin
            frame_cnt   <= '0;
            prev_page   <= 4'hf; // sweep starts at page 15
            clearing    <= 1'b1; // 16 cycles, all pages
            req_clr     <= 1'b0;
            running     <= 1'b0; // stop until run command
            rd_page     <= '0;
            rd_ptr      <= '0;
            xfer_active <= 1'b0; // a running transfer no longer counts
            busy        <= 1'b0;
        end else begin
            req_clr <= frame_sync || (req_clr && !(clear_en && !clearing));
            if (clear_en) begin
                prev_page <= frame_cnt;
                frame_cnt <= frame_cnt + 4'd1;
                if (clearing && frame_cnt == 4'hf) begin
                    clearing <= 1'b0; // last page done
                end
            end
            if (run_set) begin
                running <= run_val;
            end
            // read side
            if (xfer_start) begin
                xfer_active <= 1'b1;
            end else if (xfer_done) begin
                xfer_active <= 1'b0;
            end
            if (xfer_done && xfer_active) begin
                rd_ptr <= rd_ptr + 6'd1; // word sent
            end else if (page_inc) begin
                rd_page <= rd_page + 4'd1;
                rd_ptr  <= '0;
            end
            busy <= clearing || xfer_active || has_words || (rd_page != frame_cnt);
        end
    end

endmodule

/* logic/cmd_buffer.sv */
/*
  command buffer
  16 pages x 64 words, 32-bit write, registered byte read msb first
*/
`timescale 1ns/1ns
`include "sensor_i2c_settings.svh"

module cmd_buffer (
    input  logic                   mclk,
    input  logic                   we,
    input  i2c_seq_pkg::page_t     wr_page,
    input  i2c_seq_pkg::ptr_t      wr_ptr,
    input  i2c_seq_pkg::cmd_word_t wr_data,
    input  i2c_seq_pkg::page_t     rd_page,
    input  i2c_seq_pkg::ptr_t      rd_ptr,
    input  logic [1:0]             byte_sel, // 0 = bits 31:24
    input  logic                   re,
    output i2c_bus_pkg::byte_t     rd_byte
);

    i2c_seq_pkg::cmd_word_t mem [`SENSI2C_PAGES * `SENSI2C_PAGE_DEPTH];
    i2c_seq_pkg::cmd_word_t rd_word; // addressed word before byte pick

    assign rd_word = mem[{rd_page, rd_ptr}];

    always_ff @(posedge mclk) begin
        if (we) begin
            mem[{wr_page, wr_ptr}] <= wr_data;
        end
        if (re) begin
            rd_byte <= rd_word[8 * (3 - byte_sel) +: 8]; // ready next cycle
        end
    end

endmodule

/* logic/i2c_bit_timer.sv */
/*
  i2c bit timer
  quarter scl period strobes and the slot counter of a byte (8 bits + ack)
*/
`timescale 1ns/1ns
`include "sensor_i2c_settings.svh"

module i2c_bit_timer (
    input  logic       mclk,
    input  logic       reset_cmd,
    input  logic       enable,
    output logic       quarter, // one mclk per quarter period
    output logic [3:0] slot     // 0..7 data bits, 8 ack
);

    logic [7:0] div_cnt; // mclk cycles inside a quarter
    logic [1:0] qph;     // quarter inside a bit

    assign quarter = enable && (div_cnt == 8'(`SENSI2C_QUARTER_DLY - 1));

    always_ff @(posedge mclk) begin
        if (reset_cmd || !enable) begin
            div_cnt <= '0; // restart on every enable
            qph     <= '0;
            slot    <= '0;
        end else if (quarter) begin
            div_cnt <= '0;
            qph     <= qph + 2'd1;
            if (qph == 2'd3) begin
                slot <= (slot == 4'd8) ? 4'd0 : slot + 4'd1; // next bit
            end
        end else begin
            div_cnt <= div_cnt + 8'd1;
        end
    end

endmodule

/* logic/i2c_byte_fsm.sv */
/*
  i2c transaction FSM
  start, four bytes msb first each with an ack slot, stop;
  sda moves only with scl low except at start and stop
*/
`timescale 1ns/1ns

module i2c_byte_fsm (
    input  logic               mclk,
    input  logic               reset_cmd,
    input  logic               word_ready,
    input  logic               running,
    input  logic               quarter,
    input  logic [3:0]         slot,
    input  i2c_bus_pkg::byte_t rd_byte,
    output logic               xfer_start,
    output logic               xfer_done,
    output logic [1:0]         byte_sel,
    output logic               re,
    output logic               timer_en,
    output logic               scl_out,
    output logic               sda_out,
    output logic               sda_en,
    output logic               scl_en
);

    i2c_bus_pkg::byte_state_t state;
    i2c_bus_pkg::byte_t       shreg; // byte being shifted out
    logic [1:0]               ph;    // quarter inside the bit
    logic                     bit_end;

    assign bit_end = quarter && (ph == 2'd3);

    always_ff @(posedge mclk) begin
        if (reset_cmd) begin
            state      <= i2c_bus_pkg::st_idle;
            xfer_start <= 1'b0;
            xfer_done  <= 1'b0;
            re         <= 1'b0;
            timer_en   <= 1'b0;
            byte_sel   <= '0;
            ph         <= '0;
        end else begin
            xfer_start <= 1'b0;
            xfer_done  <= 1'b0;
            re         <= 1'b0;
            if (!timer_en) begin
                ph <= '0;
            end else if (quarter) begin
                ph <= ph + 2'd1;
            end
            case (state)
                i2c_bus_pkg::st_idle: begin
                    if (word_ready && running && !xfer_done) begin // pointer settles first
                        state      <= i2c_bus_pkg::st_start;
                        xfer_start <= 1'b1;
                        timer_en   <= 1'b1;
                        byte_sel   <= 2'd0;
                        re         <= 1'b1; // fetch first byte
                    end
                end
                i2c_bus_pkg::st_start: begin
                    if (bit_end) begin
                        state    <= i2c_bus_pkg::st_bits;
                        timer_en <= 1'b0; // restart slot count
                        shreg    <= rd_byte;
                    end
                end
                i2c_bus_pkg::st_bits: begin
                    if (!timer_en) begin
                        timer_en <= 1'b1;
                    end else if (bit_end) begin
                        shreg <= {shreg[6:0], 1'b1};
                        if (slot == 4'd7) begin
                            state    <= i2c_bus_pkg::st_ack;
                            byte_sel <= byte_sel + 2'd1;    // wraps to 0 after the last byte
                            re       <= (byte_sel != 2'd3); // prefetch next byte
                        end
                    end
                end
                i2c_bus_pkg::st_ack: begin
                    if (bit_end) begin
                        if (byte_sel == 2'd0) begin // all four bytes out
                            state    <= i2c_bus_pkg::st_stop;
                            timer_en <= 1'b0; // stop bit starts at ph 0
                        end else begin
                            state <= i2c_bus_pkg::st_bits;
                            shreg <= rd_byte;
                        end
                    end
                end
                i2c_bus_pkg::st_stop: begin
                    if (!timer_en) begin
                        timer_en <= 1'b1;
                    end else if (bit_end) begin
                        state     <= i2c_bus_pkg::st_idle;
                        timer_en  <= 1'b0;
                        xfer_done <= 1'b1;
                    end
                end
                default: state <= i2c_bus_pkg::st_idle;
            endcase
        end
    end

    // line levels from state and quarter phase
    always_comb begin
        scl_out = 1'b1;
        sda_out = 1'b1;
        sda_en  = 1'b1;
        scl_en  = 1'b1;
        case (state)
            i2c_bus_pkg::st_start: begin
                sda_out = (ph < 2'd2);  // falls mid bit, scl high
                scl_out = (ph != 2'd3);
            end
            i2c_bus_pkg::st_bits: begin
                sda_out = shreg[7];
                scl_out = (ph == 2'd1) || (ph == 2'd2);
            end
            i2c_bus_pkg::st_ack: begin
                sda_en  = 1'b0; // slave owns sda
                scl_out = (ph == 2'd1) || (ph == 2'd2);
            end
            i2c_bus_pkg::st_stop: begin
                sda_out = (ph >= 2'd2); // rises with scl high
                scl_out = (ph != 2'd0);
            end
            default: begin
                sda_en = 1'b0; // bus released
                scl_en = 1'b0;
            end
        endcase
    end

endmodule

/* logic/sensor_i2c_top.sv */
/*
  sensor i2c sequencer top
  host port, page pointers, command buffer and the bus FSM with its timer
*/
`timescale 1ns/1ns

module sensor_i2c_top (
    input  logic                   mclk,
    input  logic                   reset_cmd,
    input  logic                   frame_sync,
    input  logic                   wr_req,
    input  i2c_seq_pkg::wr_kind_t  wr_kind,
    input  i2c_seq_pkg::page_t     wr_page,
    input  i2c_seq_pkg::cmd_word_t wr_data,
    output logic                   wr_ack,
    output logic                   busy,
    output logic                   scl_out,
    output logic                   sda_out,
    output logic                   scl_en,
    output logic                   sda_en
);

    logic               word_we, word_rel, page_reset, run_set, run_val;
    logic               clearing, running, word_ready;
    logic               xfer_start, xfer_done, re, timer_en, quarter;
    logic [9:0]         wr_addr;  // {page, pointer}
    logic [3:0]         slot;
    logic [1:0]         byte_sel;
    i2c_seq_pkg::page_t word_page, rd_page;
    i2c_seq_pkg::ptr_t  rd_ptr;
    i2c_bus_pkg::byte_t rd_byte;

    cmd_port i_cmd_port (
        .mclk(mclk), .reset_cmd(reset_cmd),
        .wr_req(wr_req), .wr_kind(wr_kind), .wr_page(wr_page), .wr_data(wr_data),
        .clearing(clearing), .wr_ack(wr_ack),
        .word_we(word_we), .word_rel(word_rel), .word_page(word_page),
        .page_reset(page_reset), .run_set(run_set), .run_val(run_val)
    );

    page_pointers i_page_pointers (
        .mclk(mclk), .reset_cmd(reset_cmd), .frame_sync(frame_sync),
        .word_we(word_we), .word_rel(word_rel), .word_page(word_page),
        .page_reset(page_reset), .run_set(run_set), .run_val(run_val),
        .xfer_start(xfer_start), .xfer_done(xfer_done),
        .wr_addr(wr_addr), .rd_page(rd_page), .rd_ptr(rd_ptr),
        .word_ready(word_ready), .running(running), .clearing(clearing), .busy(busy)
    );

    cmd_buffer i_cmd_buffer (
        .mclk(mclk), .we(word_we),
        .wr_page(wr_addr[9:6]), .wr_ptr(wr_addr[5:0]), .wr_data(wr_data), // host data still held
        .rd_page(rd_page), .rd_ptr(rd_ptr), .byte_sel(byte_sel), .re(re),
        .rd_byte(rd_byte)
    );

    i2c_bit_timer i_bit_timer (
        .mclk(mclk), .reset_cmd(reset_cmd), .enable(timer_en),
        .quarter(quarter), .slot(slot)
    );

    i2c_byte_fsm i_byte_fsm (
        .mclk(mclk), .reset_cmd(reset_cmd),
        .word_ready(word_ready), .running(running),
        .quarter(quarter), .slot(slot), .rd_byte(rd_byte),
        .xfer_start(xfer_start), .xfer_done(xfer_done),
        .byte_sel(byte_sel), .re(re), .timer_en(timer_en),
        .scl_out(scl_out), .sda_out(sda_out), .sda_en(sda_en), .scl_en(scl_en)
    );

endmodule

/* tb/sensor_i2c_properties.sv */
/*
  sequencer properties
  host handshake order, sda discipline while scl is high,
  released bus lines after reset
*/
`timescale 1ns/1ns

module sensor_i2c_properties (
    input logic mclk,
    input logic reset_cmd,
    input logic wr_req,
    input logic wr_ack,
    input logic scl_out,
    input logic sda_out,
    input logic scl_en,
    input logic sda_en
);

    logic scl_line;   // with pull-up
    logic sda_line;
    logic scl_q;
    logic sda_q;
    logic start_ev;   // sda falls, scl high
    logic stop_ev;    // sda rises, scl high
    logic open_frame; // between start and stop

    assign scl_line = scl_en ? scl_out : 1'b1;
    assign sda_line = sda_en ? sda_out : 1'b1;
    assign start_ev = scl_line && scl_q && sda_q && !sda_line;
    assign stop_ev  = scl_line && scl_q && !sda_q && sda_line;

    always_ff @(posedge mclk) begin
        if (reset_cmd) begin
            scl_q      <= 1'b1;
            sda_q      <= 1'b1;
            open_frame <= 1'b0;
        end else begin
            scl_q <= scl_line;
            sda_q <= sda_line;
            if (start_ev) begin
                open_frame <= 1'b1;
            end else if (stop_ev) begin
                open_frame <= 1'b0;
            end
        end
    end

    ack_rise_needs_req: assert property (@(posedge mclk) disable iff (reset_cmd)
        $rose(wr_ack) |-> $past(wr_req))
        else $error("wr_ack rose without wr_req");

    ack_fall_after_req: assert property (@(posedge mclk) disable iff (reset_cmd)
        $fell(wr_ack) |-> !$past(wr_req))
        else $error("wr_ack fell while wr_req was still high");

    sda_fall_is_start: assert property (@(posedge mclk) disable iff (reset_cmd)
        start_ev |-> !open_frame)
        else $error("sda fell with scl high inside a transaction");

    sda_rise_is_stop: assert property (@(posedge mclk) disable iff (reset_cmd)
        stop_ev |-> open_frame)
        else $error("sda rose with scl high outside a transaction");

    lines_released_in_reset: assert property (@(posedge mclk)
        $past(reset_cmd) |-> (!sda_en && !scl_en))
        else $error("bus driven right after reset");

endmodule

/* tb/sensor_i2c_tb.sv */
/*
  sensor i2c sequencer testbench
  drives the host port and frame_sync, decodes the bus back into words
  and compares them with a model of the frame pages
*/
`timescale 1ns/1ns
`include "sensor_i2c_settings.svh"

module sensor_i2c_tb;

    localparam int XFER_CYC  = 38 * 4 * `SENSI2C_QUARTER_DLY; // mclk per bus word
    localparam int NUM_TESTS = 5;

    logic                   mclk;
    logic                   reset_cmd;
    logic                   frame_sync;
    logic                   wr_req;
    i2c_seq_pkg::wr_kind_t  wr_kind;
    i2c_seq_pkg::page_t     wr_page;
    i2c_seq_pkg::cmd_word_t wr_data;
    logic                   wr_ack;
    logic                   busy;
    logic                   scl_out;
    logic                   sda_out;
    logic                   scl_en;
    logic                   sda_en;

    integer                 seed;
    int                     errors;
    int                     n_checks;
    int                     n_rx;          // words compared so far
    i2c_seq_pkg::cmd_word_t rx_q [$];      // decoded, not yet compared
    i2c_seq_pkg::cmd_word_t page_q [16][$]; // model pages, fifo each
    i2c_seq_pkg::page_t     model_frame;
    i2c_seq_pkg::page_t     model_prev;    // page just left
    i2c_seq_pkg::page_t     model_rd;      // page the reader drains

    sensor_i2c_top i_dut (
        .mclk(mclk), .reset_cmd(reset_cmd), .frame_sync(frame_sync),
        .wr_req(wr_req), .wr_kind(wr_kind), .wr_page(wr_page), .wr_data(wr_data),
        .wr_ack(wr_ack), .busy(busy),
        .scl_out(scl_out), .sda_out(sda_out), .scl_en(scl_en), .sda_en(sda_en)
    );

    bind sensor_i2c_top sensor_i2c_properties i_props (
        .mclk(mclk), .reset_cmd(reset_cmd), .wr_req(wr_req), .wr_ack(wr_ack),
        .scl_out(scl_out), .sda_out(sda_out), .scl_en(scl_en), .sda_en(sda_en)
    );

    initial begin
        mclk = 1'b0;
        forever #5 mclk = ~mclk;
    end

    // page rule: relative adds to frame, absolute to the page just left lands now
    function automatic i2c_seq_pkg::page_t ref_page(input logic rel,
                                                    input i2c_seq_pkg::page_t page);
        if (rel) begin
            return model_frame + page; // wraps mod 16
        end else if (page == model_prev) begin
            return model_frame;
        end
        return page;
    endfunction

    // next word due on the bus, pages in frame order up to the current one
    function automatic logic pop_expected(output i2c_seq_pkg::cmd_word_t word);
        word = '0;
        while (page_q[model_rd].size() == 0 && model_rd != model_frame) begin
            model_rd = model_rd + 4'd1;
        end
        if (page_q[model_rd].size() == 0) begin
            return 1'b0; // nothing due yet
        end
        word = page_q[model_rd].pop_front();
        return 1'b1;
    endfunction

    function automatic void reset_model();
        for (int i = 0; i < 16; i++) begin
            page_q[i].delete();
        end
        model_frame = '0;
        model_prev  = 4'hf;
        model_rd    = '0;
    endfunction

    function automatic i2c_seq_pkg::cmd_word_t random_word();
        return {8'h6c, 24'($random(seed))}; // slave 0x36, write bit
    endfunction

    function automatic i2c_seq_pkg::cmd_word_t ctrl_word(input logic rst, input logic set,
                                                         input logic val);
        i2c_seq_pkg::cmd_word_t w;
        w = '0;
        w[`SENSI2C_CTRL_RESET]   = rst;
        w[`SENSI2C_CTRL_RUN_SET] = set;
        w[`SENSI2C_CTRL_RUN_VAL] = val;
        return w;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge mclk);
        #1; // drive point
    endtask

    task automatic write_cmd(input i2c_seq_pkg::wr_kind_t kind, input i2c_seq_pkg::page_t page,
                             input i2c_seq_pkg::cmd_word_t data);
        next_cycle();
        wr_kind = kind;
        wr_page = page;
        wr_data = data;
        wr_req  = 1'b1;
        do next_cycle(); while (!wr_ack); // held off while pages clear
        wr_req = 1'b0;
        do next_cycle(); while (wr_ack);  // fields held until the word is stored
        if (kind == i2c_seq_pkg::kind_ctrl) begin
            if (data[`SENSI2C_CTRL_RESET]) begin
                reset_model();
            end
        end else begin
            page_q[ref_page(kind == i2c_seq_pkg::kind_rel, page)].push_back(data);
        end
    endtask

    task automatic pulse_frame_sync();
        frame_sync = 1'b1;
        next_cycle();
        frame_sync = 1'b0;
        page_q[model_prev].delete();
        model_prev  = model_frame;
        model_frame = model_frame + 4'd1;
        repeat (2) next_cycle(); // advance settles
    endtask

    task automatic wait_idle();
        repeat (4) next_cycle(); // let busy follow the last write
        while (busy) begin
            next_cycle();
        end
    endtask

    task automatic wait_words(input int target);
        while (n_rx < target) begin
            next_cycle();
        end
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s finished, %0d errors so far", num, name, errors);
    endtask

    // bus monitor, lines sampled mid cycle, pulled high when released
    initial begin
        logic                   scl_l;
        logic                   sda_l;
        logic                   scl_q;
        logic                   sda_q;
        logic                   framing;
        int                     nbits;
        i2c_seq_pkg::cmd_word_t shift;
        scl_q   = 1'b1;
        sda_q   = 1'b1;
        framing = 1'b0;
        nbits   = 0;
        shift   = '0;
        @(negedge reset_cmd);
        forever begin
            @(negedge mclk);
            scl_l = scl_en ? scl_out : 1'b1;
            sda_l = sda_en ? sda_out : 1'b1;
            if (scl_l && scl_q && sda_q && !sda_l) begin // start
                framing = 1'b1;
                nbits   = 0;
                shift   = '0;
            end else if (scl_l && scl_q && !sda_q && sda_l) begin // stop
                if (framing && nbits == 37) begin // 36 + stop setup clock
                    rx_q.push_back(shift);
                end else begin
                    $display("bus transaction at %0t ns ended after %0d clock pulses",
                             $time, nbits);
                    errors++;
                end
                framing = 1'b0;
            end else if (framing && scl_l && !scl_q) begin
                if (nbits < 36 && (nbits % 9) != 8) begin // skip ack slots
                    shift = {shift[30:0], sda_l};
                end
                nbits++;
            end
            scl_q = scl_l;
            sda_q = sda_l;
        end
    end

    // compare each decoded word with the model
    initial begin
        i2c_seq_pkg::cmd_word_t got;
        i2c_seq_pkg::cmd_word_t exp_word;
        forever begin
            @(posedge mclk);
            if (rx_q.size() > 0) begin
                got = rx_q.pop_front();
                if (pop_expected(exp_word)) begin
                    check("bus word", got, exp_word);
                end else begin
                    $display("word %h appeared on the bus at %0t ns with none due", got, $time);
                    errors++;
                end
                n_rx++;
            end
        end
    end

    initial begin
        #(NUM_TESTS * 40 * XFER_CYC * 10);
        $display("watchdog expired after %0d transaction times", NUM_TESTS * 40);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int base;
        int left;
        seed       = 32'h9592_dfab;
        errors     = 0;
        n_checks   = 0;
        n_rx       = 0;
        reset_cmd  = 1'b1;
        frame_sync = 1'b0;
        wr_req     = 1'b0;
        wr_kind    = i2c_seq_pkg::kind_abs;
        wr_page    = '0;
        wr_data    = '0;
        reset_model();
        repeat (3) @(posedge mclk);
        #1 reset_cmd = 1'b0;

        // 1: offset 0 words go out in write order
        base = n_rx;
        write_cmd(i2c_seq_pkg::kind_ctrl, 4'd0, ctrl_word(1'b0, 1'b1, 1'b1));
        for (int i = 0; i < 4; i++) begin
            write_cmd(i2c_seq_pkg::kind_rel, 4'd0, random_word());
        end
        wait_words(base + 4);
        wait_idle();
        report_test(1, "relative offset 0");

        // 2: offset 2 waits two frames, offset 0 written later overtakes it
        base = n_rx;
        write_cmd(i2c_seq_pkg::kind_rel, 4'd2, random_word());
        write_cmd(i2c_seq_pkg::kind_rel, 4'd0, random_word());
        wait_words(base + 1);
        wait_idle();
        repeat (XFER_CYC) next_cycle();
        check("words after zero syncs", 32'(n_rx), 32'(base + 1));
        pulse_frame_sync();
        wait_idle();
        repeat (XFER_CYC) next_cycle();
        check("words after one sync", 32'(n_rx), 32'(base + 1));
        pulse_frame_sync();
        wait_words(base + 2);
        wait_idle();
        report_test(2, "relative offset 2");

        // 3: absolute pages, the page just left maps to now
        base = n_rx;
        write_cmd(i2c_seq_pkg::kind_abs, model_frame + 4'd1, random_word());
        write_cmd(i2c_seq_pkg::kind_abs, model_prev, random_word());
        write_cmd(i2c_seq_pkg::kind_abs, model_frame, random_word());
        wait_words(base + 2);
        wait_idle();
        repeat (XFER_CYC) next_cycle();
        check("words before next frame", 32'(n_rx), 32'(base + 2));
        pulse_frame_sync();
        wait_words(base + 3);
        wait_idle();
        report_test(3, "absolute pages");

        // 4: stopped sequencer holds its words
        base = n_rx;
        write_cmd(i2c_seq_pkg::kind_ctrl, 4'd0, ctrl_word(1'b0, 1'b1, 1'b0));
        for (int i = 0; i < 3; i++) begin
            write_cmd(i2c_seq_pkg::kind_rel, 4'd0, random_word());
        end
        repeat (2 * XFER_CYC) next_cycle();
        check("words while stopped", 32'(n_rx), 32'(base));
        check("busy while stopped", 32'(busy), 32'd1);
        write_cmd(i2c_seq_pkg::kind_ctrl, 4'd0, ctrl_word(1'b0, 1'b1, 1'b1));
        wait_words(base + 3);
        repeat (XFER_CYC) next_cycle(); // last stop bit and pointer update
        check("busy after drain", 32'(busy), 32'd0);
        report_test(4, "stop and run");

        // 5: reset command drops now and future pages
        base = n_rx;
        write_cmd(i2c_seq_pkg::kind_ctrl, 4'd0, ctrl_word(1'b0, 1'b1, 1'b0));
        write_cmd(i2c_seq_pkg::kind_rel, 4'd0, random_word());
        write_cmd(i2c_seq_pkg::kind_rel, 4'd0 - model_frame, random_word()); // lands in page 0
        write_cmd(i2c_seq_pkg::kind_rel, 4'd1 - model_frame, random_word()); // page 1
        write_cmd(i2c_seq_pkg::kind_ctrl, 4'd0, ctrl_word(1'b1, 1'b0, 1'b0));
        wait_idle();
        write_cmd(i2c_seq_pkg::kind_ctrl, 4'd0, ctrl_word(1'b0, 1'b1, 1'b1));
        write_cmd(i2c_seq_pkg::kind_rel, 4'd0, random_word());
        write_cmd(i2c_seq_pkg::kind_rel, 4'd0, random_word());
        wait_words(base + 2);
        wait_idle();
        pulse_frame_sync();
        wait_idle();
        repeat (XFER_CYC) next_cycle();
        check("words after reset", 32'(n_rx), 32'(base + 2));
        report_test(5, "reset command");

        left = 0;
        for (int i = 0; i < 16; i++) begin
            left += page_q[i].size();
        end
        check("model words never sent", 32'(left), 32'd0);
        $display("checks %0d, errors %0d, bus words %0d", n_checks, errors, n_rx);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+logic
logic/i2c_seq_pkg.sv
logic/i2c_bus_pkg.sv
logic/cmd_port.sv
logic/page_pointers.sv
logic/cmd_buffer.sv
logic/i2c_bit_timer.sv
logic/i2c_byte_fsm.sv
logic/sensor_i2c_top.sv
tb/sensor_i2c_properties.sv
tb/sensor_i2c_tb.sv

/* Makefile */
TOP := sensor_i2c_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir
